//--- flist.f
+incdir+tests
source/soc_bus_pkg.sv
source/data_bus_decoder.sv
source/data_ram.sv
source/led_button_regs.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/soc_data_bus.sv
tests/tb_soc_data_bus.sv

//--- tests/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ######################################################################
// Bus access, all tasks start and end 1 ns after a rising edge
// ######################################################################

task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk12MHz);
  #1;
endtask

function automatic word_t ram_addr_of(input ram_addr_t idx);
  return {20'h0, idx, 2'b00};
endfunction

function automatic word_t io_addr_of(input io_index_t idx);
  return 32'h8000_0000 | {25'h0, idx, 2'b00};
endfunction

// Byte lanes with a mask bit take the new data
function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input wmask_t m);
  word_t r;
  r = old_w;
  for (int b = 0; b < 4; b++) begin
    if (m[b]) r[8*b +: 8] = new_w[8*b +: 8];
  end
  return r;
endfunction

task automatic bus_write(input word_t addr, input word_t data, input wmask_t mask);
  mem_valid   = 1'b1;
  mem_read    = 1'b0;
  mem_address = addr;
  mem_wdata   = data;
  mem_wmask   = mask;
  wait_cycles(1);  // Accepted on this edge
  mem_valid   = 1'b0;
endtask

task automatic bus_read(input word_t addr, input wmask_t mask, output word_t data);
  mem_valid   = 1'b1;
  mem_read    = 1'b1;
  mem_address = addr;
  mem_wmask   = mask;
  wait_cycles(1);
  mem_valid   = 1'b0;
  data        = mem_rdata;  // Registered on the accepting edge
endtask

// Non-consuming status polls, bounded
task automatic poll_uart_status(input int bit_pos, input logic level, output word_t st);
  int tries;
  tries = 0;
  bus_read(io_addr_of(IO_UART), 4'h0, st);
  while (st[bit_pos] !== level && tries < 4 * CLKS_PER_BIT) begin
    bus_read(io_addr_of(IO_UART), 4'h0, st);
    tries++;
  end
  if (st[bit_pos] !== level) begin
    tmo_cnt++;
    $display("timeout: UART status bit %0d never became %0b", bit_pos, level);
  end
endtask

// 8N1 frame on i_rxd, LSB first
task automatic send_serial(input byte_t b);
  rxd = 1'b0;  // Start bit
  wait_cycles(CLKS_PER_BIT);
  for (int i = 0; i < 8; i++) begin
    rxd = b[i];
    wait_cycles(CLKS_PER_BIT);
  end
  rxd = 1'b1;  // Stop bit, line stays idle after
  wait_cycles(CLKS_PER_BIT);
endtask

// ######################################################################
// Directed tests
// ######################################################################

task automatic test_ram();
  ram_addr_t idx;
  ram_addr_t used [$];
  ram_addr_t other;
  word_t     data;
  wmask_t    mask;
  word_t     rd;
  for (int n = 0; n < 24; n++) begin
    idx  = ram_addr_t'(rand_bits(10));
    data = rand_bits(32);
    mask = wmask_t'(rand_bits(4));
    bus_write(ram_addr_of(idx), data, mask);
    ram_model[idx] = merge_bytes(ram_model[idx], data, mask);
    used.push_back(idx);
  end
  foreach (used[i]) begin
    bus_read(ram_addr_of(used[i]), 4'hf, rd);
    if (rd !== ram_model[used[i]]) flag_mismatch("o_mem_rdata", rd, ram_model[used[i]]);
  end
  // Stalled read of another word must not disturb the held data
  other = ~used[0];
  bus_write(ram_addr_of(other), ~ram_model[used[0]], 4'hf);  // Differs from the held word
  ram_model[other] = ~ram_model[used[0]];
  bus_read(ram_addr_of(used[0]), 4'hf, rd);
  mem_stall   = 1'b1;
  mem_valid   = 1'b1;
  mem_read    = 1'b1;
  mem_address = ram_addr_of(other);
  repeat (3) begin
    wait_cycles(1);
    if (mem_rdata !== ram_model[used[0]]) begin
      flag_mismatch("o_mem_rdata stalled", mem_rdata, ram_model[used[0]]);
    end
  end
  mem_valid = 1'b0;
  mem_stall = 1'b0;
endtask

task automatic test_unmapped();
  word_t keep;
  word_t rd;
  keep = rand_bits(32);
  key  = 4'h0;  // All pressed, a button alias would read nonzero
  bus_write(ram_addr_of(10'd5), keep, 4'hf);
  ram_model[5] = keep;
  bus_read(32'h0000_1014, 4'hf, rd);  // Would alias word 5 without bits 14..12
  if (rd !== '0) flag_mismatch("o_mem_rdata 0x1014", rd, '0);
  bus_read(io_addr_of(5'd2), 4'hf, rd);
  if (rd !== '0) flag_mismatch("o_mem_rdata io 2", rd, '0);
  bus_read(io_addr_of(5'd10), 4'hf, rd);
  if (rd !== '0) flag_mismatch("o_mem_rdata io 10", rd, '0);
  key = 4'hf;
  bus_write(32'h0000_1014, ~keep, 4'hf);
  bus_write(io_addr_of(5'd2), ~keep, 4'hf);
  bus_read(ram_addr_of(10'd5), 4'hf, rd);
  if (rd !== keep) flag_mismatch("o_mem_rdata word 5", rd, keep);
endtask

task automatic test_leds();
  word_t  model;
  word_t  data;
  wmask_t mask;
  word_t  rd;
  model = '0;
  if (leds !== model) flag_mismatch("o_leds", leds, model);
  for (int n = 0; n < 6; n++) begin
    data  = rand_bits(32);
    mask  = wmask_t'(rand_bits(4));
    bus_write(io_addr_of(IO_LEDS), data, mask);
    model = merge_bytes(model, data, mask);
    if (leds !== model) flag_mismatch("o_leds", leds, model);
    bus_read(io_addr_of(IO_LEDS), 4'hf, rd);
    if (rd !== model) flag_mismatch("o_mem_rdata leds", rd, model);
  end
endtask

task automatic test_buttons();
  logic [3:0] k;
  word_t      rd;
  word_t      exp;
  for (int v = 0; v < 16; v++) begin
    k   = v[3:0];
    key = k;
    bus_read(io_addr_of(IO_BUTTONS), 4'hf, rd);
    exp = 32'd15 - v;  // Pressed reads as 1
    if (rd !== exp) flag_mismatch("o_mem_rdata keys", rd, exp);
  end
  key = 4'hf;
endtask

task automatic test_uart_tx();
  byte_t b;
  word_t st;
  word_t idle_st;
  int    n;
  idle_st = (32'h1 << UART_TX_READY_BIT) | (32'h1 << UART_RX_EMPTY_BIT);
  bus_read(io_addr_of(IO_UART), 4'h0, st);
  if (st !== idle_st) flag_mismatch("uart status", st, idle_st);
  b = byte_t'(rand_bits(8));
  bus_write(io_addr_of(IO_UART), {24'h0, b}, 4'b0001);
  n = 0;
  while (txd === 1'b1 && n < 8) begin
    wait_cycles(1);
    n++;
  end
  if (txd !== 1'b0) begin
    tmo_cnt++;
    $display("timeout: no start bit on o_txd after the UART write");
    return;
  end
  wait_cycles(CLKS_PER_BIT / 2);  // Centre of the start bit
  if (txd !== 1'b0) flag_mismatch("o_txd start", txd, 0);
  bus_read(io_addr_of(IO_UART), 4'h0, st);
  if (st[UART_TX_READY_BIT] !== 1'b0) flag_mismatch("tx_ready", st[UART_TX_READY_BIT], 0);
  bus_write(io_addr_of(IO_UART), {24'h0, byte_t'(rand_bits(8))}, 4'b0001);  // Busy
  wait_cycles(CLKS_PER_BIT - 2);  // Two bus cycles already spent
  for (int i = 0; i < 8; i++) begin
    if (txd !== b[i]) flag_mismatch($sformatf("o_txd bit %0d", i), txd, b[i]);
    wait_cycles(CLKS_PER_BIT);
  end
  if (txd !== 1'b1) flag_mismatch("o_txd stop", txd, 1);
  poll_uart_status(UART_TX_READY_BIT, 1'b1, st);
  // Line must stay idle, the busy write left no frame behind
  for (int i = 0; i < 2 * CLKS_PER_BIT; i++) begin
    if (txd !== 1'b1) begin
      flag_mismatch("o_txd idle", txd, 1);
      break;
    end
    wait_cycles(1);
  end
endtask

task automatic test_uart_rx();
  byte_t b;
  word_t st;
  word_t exp;
  b = byte_t'(rand_bits(8));
  send_serial(b);
  poll_uart_status(UART_RX_EMPTY_BIT, 1'b0, st);
  exp = (32'h1 << UART_TX_READY_BIT) | {24'h0, b};
  if (st !== exp) flag_mismatch("uart status rx", st, exp);
  bus_read(io_addr_of(IO_UART), 4'b0001, st);  // Consuming read
  if (st !== exp) flag_mismatch("uart status consume", st, exp);
  bus_read(io_addr_of(IO_UART), 4'h0, st);
  exp = (32'h1 << UART_TX_READY_BIT) | (32'h1 << UART_RX_EMPTY_BIT);
  if (st !== exp) flag_mismatch("uart status empty", st, exp);
endtask

`endif

//--- tests/tb_soc_data_bus.sv
`timescale 1ns/10ps

module tb_soc_data_bus;
  import soc_bus_pkg::*;

  logic       clk12MHz;
  logic       cpu_rst;
  logic       mem_valid;
  logic       mem_read;
  logic       mem_stall;
  word_t      mem_address;
  word_t      mem_wdata;
  wmask_t     mem_wmask;
  word_t      mem_rdata;
  logic [3:0] key;      // Buttons, active low
  word_t      leds;
  logic       rxd;
  logic       txd;

  logic [31:0] lfsr_q;                 // Random source state
  int          err_cnt;                // Wrong values seen
  int          tmo_cnt;                // Waits that ran out
  word_t       ram_model [RAM_WORDS];  // Expected RAM contents

  soc_data_bus uut (
    .clk12MHz     (clk12MHz),
    .cpu_rst      (cpu_rst),
    .i_mem_valid  (mem_valid),
    .i_mem_read   (mem_read),
    .i_mem_stall  (mem_stall),
    .i_mem_address(mem_address),
    .i_mem_wdata  (mem_wdata),
    .i_mem_wmask  (mem_wmask),
    .o_mem_rdata  (mem_rdata),
    .i_key        (key),
    .o_leds       (leds),
    .i_rxd        (rxd),
    .o_txd        (txd)
  );

  initial begin
    clk12MHz = 1'b0;
    forever #4 clk12MHz = ~clk12MHz;  // 8 ns period
  end

  // ####################################################################
  // Random numbers and mismatch report
  // ####################################################################

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // One LFSR step per bit, newest bit lands in the LSB
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic flag_mismatch(input string name, input word_t got, input word_t exp);
    err_cnt++;
    $display("error: %s got %h exp %h at %0t", name, got, exp, $time);
  endtask

  `include "tb_tasks.svh"

  // ####################################################################
  // Test sequence
  // ####################################################################

  initial begin
    lfsr_q      = 32'h2449;
    err_cnt     = 0;
    tmo_cnt     = 0;
    cpu_rst     = 1'b1;
    mem_valid   = 1'b0;
    mem_read    = 1'b0;
    mem_stall   = 1'b0;
    mem_address = '0;
    mem_wdata   = '0;
    mem_wmask   = '0;
    key         = 4'hf;  // Nothing pressed
    rxd         = 1'b1;  // Serial line idle
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram_model[i] = '0;  // RAM starts cleared
    end
    repeat (2) @(posedge clk12MHz);
    #1;
    cpu_rst = 1'b0;
    if (mem_rdata !== '0) flag_mismatch("o_mem_rdata", mem_rdata, '0);
    if (txd !== 1'b1) flag_mismatch("o_txd", txd, 1);

    test_leds();
    test_buttons();
    test_ram();
    test_unmapped();
    test_uart_tx();
    test_uart_rx();

    $display("errors: %0d wrong values, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- source/soc_data_bus.sv
`timescale 1ns/10ps

module soc_data_bus (
  input  logic                clk12MHz,
  input  logic                cpu_rst,
  input  logic                i_mem_valid,
  input  logic                i_mem_read,
  input  logic                i_mem_stall,
  input  soc_bus_pkg::word_t  i_mem_address,
  input  soc_bus_pkg::word_t  i_mem_wdata,
  input  soc_bus_pkg::wmask_t i_mem_wmask,
  output soc_bus_pkg::word_t  o_mem_rdata,
  input  logic [3:0]          i_key,
  output soc_bus_pkg::word_t  o_leds,
  input  logic                i_rxd,
  output logic                o_txd
);
  import soc_bus_pkg::*;

  logic      ram_sel;   // Accepted-access strobes
  logic      leds_sel;
  logic      uart_sel;
  ram_addr_t ram_addr;
  word_t     ram_rdata;
  word_t     leds_rdata;
  word_t     key_rdata;
  word_t     uart_rdata;

  // ######################################################################
  // Decode and read-back mux
  // ######################################################################

  data_bus_decoder u_decoder (
    .clk12MHz     (clk12MHz),
    .cpu_rst      (cpu_rst),
    .i_mem_valid  (i_mem_valid),
    .i_mem_read   (i_mem_read),
    .i_mem_stall  (i_mem_stall),
    .i_mem_address(i_mem_address),
    .i_ram_rdata  (ram_rdata),
    .i_leds_rdata (leds_rdata),
    .i_key_rdata  (key_rdata),
    .i_uart_rdata (uart_rdata),
    .o_ram_sel    (ram_sel),
    .o_leds_sel   (leds_sel),
    .o_uart_sel   (uart_sel),
    .o_ram_addr   (ram_addr),
    .o_mem_rdata  (o_mem_rdata)
  );

  // ######################################################################
  // Targets
  // ######################################################################

  data_ram u_ram (              // 0x0000_0000, 4 KiB
    .clk12MHz(clk12MHz),
    .i_sel   (ram_sel),
    .i_read  (i_mem_read),
    .i_addr  (ram_addr),
    .i_wdata (i_mem_wdata),
    .i_wmask (i_mem_wmask),
    .o_rdata (ram_rdata)
  );

  led_button_regs u_led_btn (   // 0x8000_0000 and 0x8000_0004
    .clk12MHz    (clk12MHz),
    .cpu_rst     (cpu_rst),
    .i_sel       (leds_sel),
    .i_read      (i_mem_read),
    .i_wdata     (i_mem_wdata),
    .i_wmask     (i_mem_wmask),
    .i_key       (i_key),
    .o_leds      (o_leds),
    .o_leds_rdata(leds_rdata),
    .o_key_rdata (key_rdata)
  );

  uart_regs u_uart (            // 0x8000_000C
    .clk12MHz    (clk12MHz),
    .cpu_rst     (cpu_rst),
    .i_sel       (uart_sel),
    .i_read      (i_mem_read),
    .i_wdata     (i_mem_wdata),
    .i_wmask     (i_mem_wmask),
    .i_rxd       (i_rxd),
    .o_txd       (o_txd),
    .o_uart_rdata(uart_rdata)
  );

endmodule

//--- source/uart_regs.sv
`timescale 1ns/10ps

module uart_regs (
  input  logic                clk12MHz,
  input  logic                cpu_rst,
  input  logic                i_sel,
  input  logic                i_read,
  input  soc_bus_pkg::word_t  i_wdata,
  input  soc_bus_pkg::wmask_t i_wmask,
  input  logic                i_rxd,
  output logic                o_txd,
  output soc_bus_pkg::word_t  o_uart_rdata
);
  import soc_bus_pkg::*;

  logic  tx_go;        // Accepted byte for the transmitter
  logic  tx_start_q;
  byte_t tx_data_q;
  logic  tx_busy;
  logic  tx_done;
  logic  tx_ready;
  logic  rx_consume;   // Lane-0 read empties the receive slot
  logic  rx_strobe;
  byte_t rx_data;
  byte_t rx_byte_q;
  logic  rx_empty;

  assign tx_go      = i_sel && !i_read && i_wmask[0] && tx_ready;  // Busy writes dropped
  assign rx_consume = i_sel && i_read && i_wmask[0];

  // ######################################################################
  // Transmit side
  // ######################################################################

  always_ff @(posedge clk12MHz) begin
    if (cpu_rst) begin
      tx_start_q <= 1'b0;
      tx_ready   <= 1'b1;
    end else begin
      tx_start_q <= tx_go;                                // Start one cycle later
      if (tx_go || tx_busy) tx_ready <= 1'b0;
      else if (tx_done)     tx_ready <= 1'b1;             // Frame finished
    end
  end

  always_ff @(posedge clk12MHz) begin
    if (tx_go) tx_data_q <= i_wdata[7:0];
  end

  uart_tx u_tx (
    .clk12MHz  (clk12MHz),
    .cpu_rst   (cpu_rst),
    .i_tx_start(tx_start_q),
    .i_tx_data (tx_data_q),
    .o_txd     (o_txd),
    .o_tx_busy (tx_busy),
    .o_tx_done (tx_done)
  );

  // ######################################################################
  // Receive side
  // ######################################################################

  always_ff @(posedge clk12MHz) begin
    if (cpu_rst) begin
      rx_empty  <= 1'b1;
      rx_byte_q <= '0;
    end else if (rx_strobe) begin
      rx_empty  <= 1'b0;
      rx_byte_q <= rx_data;  // New byte wins
    end else if (rx_consume) begin
      rx_empty  <= 1'b1;
      rx_byte_q <= '0;
    end
  end

  uart_rx u_rx (
    .clk12MHz   (clk12MHz),
    .cpu_rst    (cpu_rst),
    .i_rxd      (i_rxd),
    .o_rx_strobe(rx_strobe),
    .o_rx_data  (rx_data)
  );

  // Status word
  always_comb begin
    o_uart_rdata                    = '0;
    o_uart_rdata[7:0]               = rx_byte_q;
    o_uart_rdata[UART_TX_READY_BIT] = tx_ready;
    o_uart_rdata[UART_RX_EMPTY_BIT] = rx_empty;
  end

  a_rx_no_overlap: assert property (@(posedge clk12MHz) disable iff (cpu_rst)
    !(rx_strobe && rx_consume));

endmodule

//--- source/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
  input  logic               clk12MHz,
  input  logic               cpu_rst,
  input  logic               i_rxd,
  output logic               o_rx_strobe,
  output soc_bus_pkg::byte_t o_rx_data
);
  import soc_bus_pkg::*;

  logic                            rxd_meta;
  logic                            rxd_sync;  // Line after two flops
  rx_state_t                       state;
  logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt;
  logic [2:0]                      bit_cnt;
  byte_t                           shift_q;
  logic                            bit_end;
  logic                            half_bit;

  // ######################################################################
  // Input synchronizer
  // ######################################################################

  always_ff @(posedge clk12MHz) begin
    if (cpu_rst) begin
      rxd_meta <= 1'b1;  // Idle level
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= i_rxd;
      rxd_sync <= rxd_meta;
    end
  end

  assign bit_end  = (baud_cnt == CLKS_PER_BIT - 1);
  assign half_bit = (baud_cnt == CLKS_PER_BIT / 2 - 1);

  // ######################################################################
  // Receive FSM, samples at mid-bit
  // ######################################################################

  always_ff @(posedge clk12MHz) begin
    if (cpu_rst) begin
      state       <= RX_IDLE;
      baud_cnt    <= '0;
      bit_cnt     <= '0;
      o_rx_strobe <= 1'b0;
    end else begin
      o_rx_strobe <= 1'b0;
      baud_cnt    <= baud_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (!rxd_sync) state <= RX_START;  // Falling edge seen
        end
        RX_START: if (half_bit) begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          // High again at mid-bit means a glitch
          state    <= rxd_sync ? RX_IDLE : RX_DATA;
        end
        RX_DATA: if (bit_end) begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) state <= RX_STOP;
        end
        RX_STOP: if (bit_end) begin
          state       <= RX_IDLE;
          o_rx_strobe <= rxd_sync;  // Framing error drops the byte
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, shift in from the top
  always_ff @(posedge clk12MHz) begin
    if (state == RX_DATA && bit_end) begin
      shift_q <= {rxd_sync, shift_q[7:1]};
    end
  end

  assign o_rx_data = shift_q;

endmodule

//--- source/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
  input  logic               clk12MHz,
  input  logic               cpu_rst,
  input  logic               i_tx_start,
  input  soc_bus_pkg::byte_t i_tx_data,
  output logic               o_txd,
  output logic               o_tx_busy,
  output logic               o_tx_done
);
  import soc_bus_pkg::*;

  tx_state_t                       state;
  logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt;  // Cycles inside the current bit
  logic [2:0]                      bit_cnt;   // Data bit being sent
  byte_t                           shift_q;
  logic                            bit_end;

  assign bit_end   = (baud_cnt == CLKS_PER_BIT - 1);
  assign o_tx_busy = (state != TX_IDLE);

  // ######################################################################
  // Frame FSM, 8N1 LSB first
  // ######################################################################

  always_ff @(posedge clk12MHz) begin
    if (cpu_rst) begin
      state     <= TX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      o_txd     <= 1'b1;  // Line idles high
      o_tx_done <= 1'b0;
    end else begin
      o_tx_done <= 1'b0;
      baud_cnt  <= bit_end ? '0 : baud_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          baud_cnt <= '0;  // Full-length start bit
          if (i_tx_start) begin
            state <= TX_START;
            o_txd <= 1'b0;  // Start bit
          end
        end
        TX_START: if (bit_end) begin
          state   <= TX_DATA;
          bit_cnt <= '0;
          o_txd   <= shift_q[0];  // Bit 0
        end
        TX_DATA: if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            state <= TX_STOP;
            o_txd <= 1'b1;  // Stop bit
          end else begin
            o_txd <= shift_q[0];
          end
        end
        TX_STOP: if (bit_end) begin
          state     <= TX_IDLE;
          o_tx_done <= 1'b1;  // Single pulse, busy already low
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Data shifter, next bit always in position 0
  always_ff @(posedge clk12MHz) begin
    if (state == TX_IDLE && i_tx_start) begin
      shift_q <= i_tx_data;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // Start only arrives while the line is idle
  a_start_when_idle: assert property (@(posedge clk12MHz) disable iff (cpu_rst)
    i_tx_start |-> !o_tx_busy);

endmodule

//--- source/led_button_regs.sv
`timescale 1ns/10ps

module led_button_regs (
  input  logic                clk12MHz,
  input  logic                cpu_rst,
  input  logic                i_sel,
  input  logic                i_read,
  input  soc_bus_pkg::word_t  i_wdata,
  input  soc_bus_pkg::wmask_t i_wmask,
  input  logic [3:0]          i_key,
  output soc_bus_pkg::word_t  o_leds,
  output soc_bus_pkg::word_t  o_leds_rdata,
  output soc_bus_pkg::word_t  o_key_rdata
);
  import soc_bus_pkg::*;

  word_t leds_q;  // LED bytes 4..1, byte 1 in the low lane
  logic  led_wr;

  assign led_wr = i_sel && !i_read;

  // LED data register written lane by lane
  always_ff @(posedge clk12MHz) begin
    if (cpu_rst) begin
      leds_q <= '0;
    end else if (led_wr) begin
      for (int lane = 0; lane < $bits(wmask_t); lane++) begin
        if (i_wmask[lane]) begin
          leds_q[8*lane +: 8] <= i_wdata[8*lane +: 8];
        end
      end
    end
  end

  assign o_leds       = leds_q;  // Straight to the pins
  assign o_leds_rdata = leds_q;  // Read back the same word

  // Keys are active low on the board
  assign o_key_rdata = {28'b0, ~i_key};

endmodule

//--- source/data_ram.sv
`timescale 1ns/10ps

module data_ram (
  input  logic                   clk12MHz,
  input  logic                   i_sel,
  input  logic                   i_read,
  input  soc_bus_pkg::ram_addr_t i_addr,
  input  soc_bus_pkg::word_t     i_wdata,
  input  soc_bus_pkg::wmask_t    i_wmask,
  output soc_bus_pkg::word_t     o_rdata
);
  import soc_bus_pkg::*;

  word_t mem [RAM_WORDS];  // 1024 x 32 block RAM
  logic  wr_en;
  logic  rd_en;

  assign wr_en = i_sel && !i_read;
  assign rd_en = i_sel && i_read;

  // Block RAM powers up cleared
  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // ######################################################################
  // Byte-masked write port and registered read
  // ######################################################################

  always @(posedge clk12MHz) begin
    if (wr_en) begin
      for (int lane = 0; lane < $bits(wmask_t); lane++) begin
        if (i_wmask[lane]) begin
          mem[i_addr][8*lane +: 8] <= i_wdata[8*lane +: 8];  // Only the masked lane
        end
      end
    end
    if (rd_en) begin
      o_rdata <= mem[i_addr];  // Held until the next read
    end
  end

endmodule

//--- source/data_bus_decoder.sv
`timescale 1ns/10ps

module data_bus_decoder (
  input  logic                   clk12MHz,
  input  logic                   cpu_rst,
  input  logic                   i_mem_valid,
  input  logic                   i_mem_read,
  input  logic                   i_mem_stall,
  input  soc_bus_pkg::word_t     i_mem_address,
  input  soc_bus_pkg::word_t     i_ram_rdata,
  input  soc_bus_pkg::word_t     i_leds_rdata,
  input  soc_bus_pkg::word_t     i_key_rdata,
  input  soc_bus_pkg::word_t     i_uart_rdata,
  output logic                   o_ram_sel,
  output logic                   o_leds_sel,
  output logic                   o_uart_sel,
  output soc_bus_pkg::ram_addr_t o_ram_addr,
  output soc_bus_pkg::word_t     o_mem_rdata
);
  import soc_bus_pkg::*;

  logic      accept;     // Strobe qualified by stall
  logic      ram_hit;
  logic      io_hit;
  io_index_t io_idx;
  word_t     io_word;    // IO data before the read register
  word_t     io_data_q;
  logic      ram_sig_q;  // Source of the last accepted read
  logic      io_sig_q;

  assign accept  = i_mem_valid && !i_mem_stall;
  assign ram_hit = ({i_mem_address[31], i_mem_address[14:12]} == 4'b0000);
  assign io_hit  = i_mem_address[31];
  assign io_idx  = i_mem_address[6:2];

  assign o_ram_addr = i_mem_address[11:2];
  assign o_ram_sel  = accept && ram_hit;
  assign o_leds_sel = accept && io_hit && (io_idx == IO_LEDS);
  assign o_uart_sel = accept && io_hit && (io_idx == IO_UART);

  // Unmapped IO slots fall through as zero
  assign io_word = ((io_hit && io_idx == IO_BUTTONS) ? i_key_rdata  : '0) |
                   ((io_hit && io_idx == IO_LEDS)    ? i_leds_rdata : '0) |
                   ((io_hit && io_idx == IO_UART)    ? i_uart_rdata : '0);

  // Read source flags, held until the next accepted read
  always_ff @(posedge clk12MHz) begin
    if (cpu_rst) begin
      ram_sig_q <= 1'b0;
      io_sig_q  <= 1'b0;
    end else if (accept && i_mem_read) begin
      ram_sig_q <= ram_hit;
      io_sig_q  <= io_hit;
    end
  end

  always_ff @(posedge clk12MHz) begin
    if (accept && i_mem_read) io_data_q <= io_word;  // IO read register
  end

  // Zero-forcing OR mux
  assign o_mem_rdata = (ram_sig_q ? i_ram_rdata : '0) |
                       (io_sig_q  ? io_data_q   : '0);

  // Stalled cycles leave the read data untouched, RAM port included
  a_stall_hold: assert property (@(posedge clk12MHz) disable iff (cpu_rst)
    i_mem_stall |=> $stable(o_mem_rdata));

endmodule

//--- source/soc_bus_pkg.sv
package soc_bus_pkg;

  // ######################################################################
  // Bus and memory widths
  // ######################################################################

  typedef logic [31:0] word_t;      // Data bus word
  typedef logic [3:0]  wmask_t;     // One bit per byte lane
  typedef logic [7:0]  byte_t;      // Single byte lane
  typedef logic [9:0]  ram_addr_t;  // RAM word index
  typedef logic [4:0]  io_index_t;  // IO word index from address bits 6 to 2

  // ######################################################################
  // Memory map
  // ######################################################################

  localparam int RAM_WORDS = 1024;  // 4 KiB of data RAM

  // IO word slots inside the 0x8000_0000 window
  localparam io_index_t IO_BUTTONS = 5'd0;  // 0x8000_0000
  localparam io_index_t IO_LEDS    = 5'd1;  // 0x8000_0004
  localparam io_index_t IO_UART    = 5'd3;  // 0x8000_000C

  // ######################################################################
  // UART
  // ######################################################################

  // 12 MHz / 104 gives roughly 115200 baud
  localparam int CLKS_PER_BIT = 104;

  // Status word layout, received byte sits in bits 7 to 0
  localparam int UART_TX_READY_BIT = 8;
  localparam int UART_RX_EMPTY_BIT = 16;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage
